/* tb.f */
verilog/scope_pkg.sv
verilog/scope_regs.sv
verilog/sample_timer.sv
verilog/adc_spi_master.sv
verilog/scope_buffer.sv
verilog/adc_scope_top.sv
tb/adc_scope_asserts.sv
tb/adc_scope_tb.sv

/* Bender.yml */
package:
  name: adc_scope

sources:
  - files:
      - verilog/scope_pkg.sv
      - verilog/scope_regs.sv
      - verilog/sample_timer.sv
      - verilog/adc_spi_master.sv
      - verilog/scope_buffer.sv
      - verilog/adc_scope_top.sv
  - target: test
    files:
      - tb/adc_scope_asserts.sv
      - tb/adc_scope_tb.sv

/* tb/adc_scope_tb.sv */
// Runs the default six-channel, four-frame top; stream checks assume no frame lands during a drain
module adc_scope_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import scope_pkg::*;

    localparam int N_CH = 6;
    localparam int N_FRAMES = 4;
    localparam int BUF_BEATS = N_CH * N_FRAMES;
    localparam int N_BUFFERS = 3;
    localparam int TEST_PERIOD = 199;
    localparam int TEST_DIV = 1;
    localparam int FAST_PERIOD = 9;
    localparam int CYCLE_LIMIT = N_BUFFERS * N_FRAMES * (TEST_PERIOD + 1) + 2000;

    logic ss, rst, psel, penable, pwrite, pready, pslverr;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic [APB_DATA_BITS-1:0] pwdata, prdata;
    logic [N_CH-1:0] miso;
    logic cs_n, sclk, dma_done, out_last, out_valid, out_ready;
    logic [SAMPLE_BITS-1:0] out_data;
    logic [CHANNEL_BITS-1:0] out_channel;

    int seed = 32'h6644a147;
    int sample_errors, channel_errors, apb_errors, flag_errors, other_errors;
    int cycles, frames_done, beats, buffers_done, conv_base, dropped_total;
    bit checking = 1'b1;

    // ADC word for channel chan in conversion conv wrapped to 14 bits
    function automatic logic [SAMPLE_BITS-1:0] expected_sample(input int chan, input int conv);
        int raw;
        raw = 32'h1110 + chan + 16 * conv;
        return SAMPLE_BITS'(raw);
    endfunction

    task automatic check_sample(input string name, input logic [SAMPLE_BITS-1:0] got,
                                input logic [SAMPLE_BITS-1:0] exp);
        if (got !== exp) begin
            sample_errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_channel(input string name, input logic [CHANNEL_BITS-1:0] got,
                                 input logic [CHANNEL_BITS-1:0] exp);
        if (got !== exp) begin
            channel_errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_apb(input string name, input logic [APB_DATA_BITS-1:0] got,
                             input logic [APB_DATA_BITS-1:0] exp);
        if (got !== exp) begin
            apb_errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // One APB transfer; read data, pready and pslverr are taken mid-cycle in the access phase
    task automatic apb_access(input logic [APB_ADDR_BITS-1:0] addr, input logic write,
                              input logic [APB_DATA_BITS-1:0] wdata,
                              output logic [APB_DATA_BITS-1:0] rdata, output logic err);
        @(posedge ss);
        #1;
        paddr = addr;
        pwrite = write;
        pwdata = wdata;
        psel = 1'b1;
        @(posedge ss);
        #1;
        penable = 1'b1;
        @(negedge ss);
        rdata = prdata;
        err = pslverr;
        check_flag("pready", pready, 1'b1);
        @(posedge ss);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic reg_write(input logic [APB_ADDR_BITS-1:0] addr, input int data);
        logic [APB_DATA_BITS-1:0] rdata;
        logic err;
        apb_access(addr, 1'b1, APB_DATA_BITS'(data), rdata, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic reg_check(input logic [APB_ADDR_BITS-1:0] addr, input string name,
                             input logic [APB_DATA_BITS-1:0] mask, input int exp);
        logic [APB_DATA_BITS-1:0] rdata;
        logic err;
        apb_access(addr, 1'b0, '0, rdata, err);
        check_flag("pslverr", err, 1'b0);
        check_apb(name, rdata & mask, APB_DATA_BITS'(exp));
    endtask

    function automatic int total_errors();
        return sample_errors + channel_errors + apb_errors + flag_errors + other_errors
               + dut_i.asserts_i.fail_count;
    endfunction

    task automatic report_counts();
        $display("Errors: sample %0d, channel %0d, apb %0d, flag %0d, other %0d, assertion %0d",
                 sample_errors, channel_errors, apb_errors, flag_errors, other_errors,
                 dut_i.asserts_i.fail_count);
    endtask

    adc_scope_top #(.n_channels(N_CH), .buffer_frames(N_FRAMES)) dut_i (.*);

    initial begin
        ss = 1'b0;
        forever #4 ss = ~ss;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge ss);
            cycles++;
        end
        $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        report_counts();
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rand_word;
        forever begin
            @(posedge ss);
            rand_word = $random(seed);
            #1 out_ready = rand_word[0];
        end
    end

    // Each ADC puts out two zeros and its 14-bit result, MSB first, changing after falling sclk
    for (genvar c = 0; c < N_CH; c++) begin : g_adc
        initial begin
            int k;
            logic [FRAME_BITS-1:0] word;
            k = 0;
            forever begin
                @(negedge cs_n);
                word = {2'b00, expected_sample(c, k)};
                #1 miso[c] = word[FRAME_BITS-1];
                for (int i = FRAME_BITS - 2; i >= 0; i--) begin
                    @(negedge sclk);
                    #1 miso[c] = word[i];
                end
                k++;
            end
        end
    end

    // Count completed conversions at the moment the buffer sees frame_valid
    initial begin
        forever begin
            @(posedge cs_n);
            if (!rst) begin
                frames_done++;
            end
        end
    end

    initial begin
        int f;
        int c;
        forever begin
            @(negedge ss);
            if (checking && !rst && out_valid && out_ready) begin
                f = (beats % BUF_BEATS) / N_CH;
                c = beats % N_CH;
                check_channel("out_channel", out_channel, CHANNEL_BITS'(c));
                check_sample("out_data", out_data, expected_sample(c, conv_base + f));
                check_flag("out_last", out_last, (beats % BUF_BEATS) == BUF_BEATS - 1);
                beats++;
                if (beats % BUF_BEATS == 0) begin
                    conv_base += N_FRAMES;
                    buffers_done++;
                end
            end
        end
    end

    initial begin
        logic [APB_DATA_BITS-1:0] rdata;
        logic err;
        int snap;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        miso = '0;
        dma_done = 1'b0;
        out_ready = 1'b0;
        repeat (8) @(posedge ss);
        #1 rst = 1'b0;

        reg_write(PERIOD, TEST_PERIOD);
        reg_check(PERIOD, "PERIOD", 32'hFFFF_FFFF, TEST_PERIOD);
        reg_write(SCLK_DIV, TEST_DIV);
        reg_check(SCLK_DIV, "SCLK_DIV", 32'hFFFF_FFFF, TEST_DIV);
        apb_access(4'h2, 1'b0, '0, rdata, err);
        check_flag("pslverr", err, 1'b1);
        check_apb("prdata", rdata, '0);

        // The second buffer sits in WAIT_DMA for two sample periods and loses those frames
        reg_write(CTRL, 1);
        for (int b = 0; b < N_BUFFERS; b++) begin
            wait (buffers_done == b + 1);
            @(posedge ss);
            #1;
            if (b == 1) begin
                snap = frames_done;
                repeat (2 * (TEST_PERIOD + 1)) @(posedge ss);
                #1;
                dropped_total += frames_done - snap;
                conv_base += frames_done - snap;
            end
            dma_done = 1'b1;
            @(posedge ss);
            #1 dma_done = 1'b0;
        end
        checking = 1'b0;
        reg_write(CTRL, 0);
        reg_check(STATUS, "STATUS", 32'hFFFF, dropped_total << 8);

        // Triggers now come faster than one SPI frame
        reg_write(PERIOD, FAST_PERIOD);
        reg_write(CTRL, 1);
        repeat (4 * (FAST_PERIOD + 1)) @(posedge ss);
        reg_check(STATUS, "STATUS[0]", 32'h1, 1);
        reg_write(CTRL, 0);
        repeat (2) @(posedge ss);
        wait (cs_n === 1'b1);
        reg_write(STATUS, 1);
        reg_check(STATUS, "STATUS[0]", 32'h1, 0);

        report_counts();
        if (total_errors() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb/adc_scope_asserts.sv */
// Bound into adc_scope_top and uses its internal busy; all checks are off while rst is high
module adc_scope_asserts (
    input logic                              ss,
    input logic                              rst,
    input logic                              busy,
    input logic                              cs_n,
    input logic                              sclk,
    input logic                              out_valid,
    input logic                              out_ready,
    input logic [scope_pkg::SAMPLE_BITS-1:0] out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // The ADCs are only selected while the SPI master runs a frame
    cs_idle_high: assert property (@(posedge ss) disable iff (rst) !busy |-> cs_n)
        else begin
            fail_count++;
            $error("cs_n is low while the SPI master is idle");
        end

    stall_stable: assert property (@(posedge ss) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            fail_count++;
            $error("out_data or out_valid changed during a stall");
        end

    // Mode 0 keeps the clock low whenever no ADC is selected
    sclk_low_deselected: assert property (@(posedge ss) disable iff (rst) cs_n |-> !sclk)
        else begin
            fail_count++;
            $error("sclk is high while cs_n is high");
        end

endmodule

bind adc_scope_top adc_scope_asserts asserts_i (
    .ss(ss),
    .rst(rst),
    .busy(busy),
    .cs_n(cs_n),
    .sclk(sclk),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data(out_data)
);

/* verilog/adc_scope_top.sv */
// Single clock domain; miso lines must already be synchronous to ss and dma_done must be a pulse
module adc_scope_top #(
    parameter int n_channels = 6,
    parameter int buffer_frames = 4
) (
    input  logic                                ss,
    input  logic                                rst,
    input  logic [scope_pkg::APB_ADDR_BITS-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [scope_pkg::APB_DATA_BITS-1:0] pwdata,
    output logic [scope_pkg::APB_DATA_BITS-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic [n_channels-1:0]               miso,
    output logic                                cs_n,
    output logic                                sclk,
    input  logic                                dma_done,
    output logic [scope_pkg::SAMPLE_BITS-1:0]   out_data,
    output logic [scope_pkg::CHANNEL_BITS-1:0]  out_channel,
    output logic                                out_last,
    output logic                                out_valid,
    input  logic                                out_ready
);
    import scope_pkg::*;

    logic                              enable;
    logic [PERIOD_BITS-1:0]            period;
    logic [DIV_BITS-1:0]               sclk_div;
    logic                              trigger;
    logic                              busy;
    logic                              frame_valid;
    logic [n_channels*SAMPLE_BITS-1:0] frame_data;
    logic                              frame_dropped;

    scope_regs regs_i (
        .ss(ss), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .busy(busy), .trigger(trigger), .frame_dropped(frame_dropped),
        .enable(enable), .period(period), .sclk_div(sclk_div)
    );

    sample_timer timer_i (
        .ss(ss), .rst(rst), .enable(enable), .period(period), .trigger(trigger)
    );

    adc_spi_master #(.n_channels(n_channels)) spi_i (
        .ss(ss), .rst(rst), .trigger(trigger), .sclk_div(sclk_div), .miso(miso),
        .cs_n(cs_n), .sclk(sclk), .busy(busy),
        .frame_valid(frame_valid), .frame_data(frame_data)
    );

    scope_buffer #(.n_channels(n_channels), .buffer_frames(buffer_frames)) buf_i (
        .ss(ss), .rst(rst),
        .frame_valid(frame_valid), .frame_data(frame_data),
        .dma_done(dma_done), .frame_dropped(frame_dropped),
        .out_data(out_data), .out_channel(out_channel), .out_last(out_last),
        .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

/* verilog/scope_buffer.sv */
// Collects buffer_frames frames, then streams them out; n_channels must not exceed eight
module scope_buffer #(
    parameter int n_channels = 6,
    parameter int buffer_frames = 4
) (
    input  logic                                          ss,
    input  logic                                          rst,
    input  logic                                          frame_valid,
    input  logic [n_channels*scope_pkg::SAMPLE_BITS-1:0]  frame_data,
    input  logic                                          dma_done,
    output logic                                          frame_dropped,
    output logic [scope_pkg::SAMPLE_BITS-1:0]             out_data,
    output logic [scope_pkg::CHANNEL_BITS-1:0]            out_channel,
    output logic                                          out_last,
    output logic                                          out_valid,
    input  logic                                          out_ready
);
    import scope_pkg::*;

    localparam int FRAME_IDX_W = (buffer_frames > 1) ? $clog2(buffer_frames) : 1;
    localparam logic [FRAME_IDX_W-1:0] FRAME_LAST = FRAME_IDX_W'(buffer_frames - 1);
    localparam logic [CHANNEL_BITS-1:0] CHAN_LAST = CHANNEL_BITS'(n_channels - 1);

    buf_state_e                     state;
    logic [n_channels*SAMPLE_BITS-1:0] mem [buffer_frames];
    logic [n_channels*SAMPLE_BITS-1:0] rd_word;
    logic [FRAME_IDX_W-1:0]         wr_ptr;
    logic [FRAME_IDX_W-1:0]         rd_frame;
    logic [CHANNEL_BITS-1:0]        rd_chan;
    logic                           wr_en;

    assign wr_en = frame_valid && (state == FILL);

    assign rd_word = mem[rd_frame];
    assign out_data = rd_word[rd_chan*SAMPLE_BITS +: SAMPLE_BITS];
    assign out_channel = rd_chan;
    assign out_valid = (state == DRAIN);
    assign out_last = out_valid && (rd_frame == FRAME_LAST) && (rd_chan == CHAN_LAST);

    always_ff @(posedge ss) begin
        if (wr_en) begin
            mem[wr_ptr] <= frame_data;
        end
    end

    always_ff @(posedge ss) begin
        if (rst) begin
            state <= FILL;
            wr_ptr <= '0;
            rd_frame <= '0;
            rd_chan <= '0;
            frame_dropped <= 1'b0;
        end else begin
            frame_dropped <= frame_valid && (state != FILL);
            case (state)
                FILL: begin
                    if (wr_en) begin
                        wr_ptr <= (wr_ptr == FRAME_LAST) ? '0 : wr_ptr + 1'b1;
                        if (wr_ptr == FRAME_LAST) begin
                            state <= DRAIN;
                        end
                    end
                end
                // Channel index runs fastest, then the frame index
                DRAIN: begin
                    if (out_ready) begin
                        if (rd_chan != CHAN_LAST) begin
                            rd_chan <= rd_chan + 1'b1;
                        end else begin
                            rd_chan <= '0;
                            rd_frame <= (rd_frame == FRAME_LAST) ? '0 : rd_frame + 1'b1;
                            if (rd_frame == FRAME_LAST) begin
                                state <= WAIT_DMA;
                            end
                        end
                    end
                end
                WAIT_DMA: begin
                    if (dma_done) begin
                        state <= FILL;
                    end
                end
                default: state <= FILL;
            endcase
        end
    end

endmodule

/* verilog/adc_spi_master.sv */
// SPI mode 0 master for ADCs sharing cs_n and sclk; sclk_div is reloaded live, so change it only while idle
module adc_spi_master #(
    parameter int n_channels = 6
) (
    input  logic                                          ss,
    input  logic                                          rst,
    input  logic                                          trigger,
    input  logic [scope_pkg::DIV_BITS-1:0]                sclk_div,
    input  logic [n_channels-1:0]                         miso,
    output logic                                          cs_n,
    output logic                                          sclk,
    output logic                                          busy,
    output logic                                          frame_valid,
    output logic [n_channels*scope_pkg::SAMPLE_BITS-1:0]  frame_data
);
    import scope_pkg::*;

    localparam int HALF_W = $clog2(2 * FRAME_BITS);
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(2 * FRAME_BITS - 1);

    spi_state_e          state;
    logic [DIV_BITS-1:0] div_cnt;
    logic [HALF_W-1:0]   half_cnt;
    logic                shift_en;

    assign busy = (state != IDLE);

    // Sample on every rising sclk, which happens at the end of an even half-period
    assign shift_en = (div_cnt == '0)
                      && ((state == SELECT) || (state == SHIFT && !sclk));

    always_ff @(posedge ss) begin
        if (rst) begin
            state <= IDLE;
            cs_n <= 1'b1;
            sclk <= 1'b0;
            div_cnt <= '0;
            half_cnt <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (trigger) begin
                        cs_n <= 1'b0;
                        div_cnt <= sclk_div;
                        half_cnt <= '0;
                        state <= SELECT;
                    end
                end
                // First half-period with sclk low while the ADCs present their MSB
                SELECT: begin
                    if (div_cnt == '0) begin
                        sclk <= 1'b1;
                        div_cnt <= sclk_div;
                        half_cnt <= half_cnt + 1'b1;
                        state <= SHIFT;
                    end else begin
                        div_cnt <= div_cnt - 1'b1;
                    end
                end
                SHIFT: begin
                    if (div_cnt == '0) begin
                        sclk <= !sclk;
                        div_cnt <= sclk_div;
                        if (half_cnt == HALF_LAST) begin
                            state <= RELEASE;
                        end else begin
                            half_cnt <= half_cnt + 1'b1;
                        end
                    end else begin
                        div_cnt <= div_cnt - 1'b1;
                    end
                end
                RELEASE: begin
                    cs_n <= 1'b1;
                    frame_valid <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // One shift register per miso line; the two leading zeros fall off the top
    for (genvar c = 0; c < n_channels; c++) begin : g_chan
        logic [FRAME_BITS-1:0] shreg;

        always_ff @(posedge ss) begin
            if (shift_en) begin
                shreg <= {shreg[FRAME_BITS-2:0], miso[c]};
            end
        end

        assign frame_data[c*SAMPLE_BITS +: SAMPLE_BITS] = shreg[SAMPLE_BITS-1:0];
    end

endmodule

/* verilog/sample_timer.sv */
// One trigger every period+1 cycles while enabled; a new period value is taken at the next reload
module sample_timer (
    input  logic                              ss,
    input  logic                              rst,
    input  logic                              enable,
    input  logic [scope_pkg::PERIOD_BITS-1:0] period,
    output logic                              trigger
);
    import scope_pkg::*;

    logic [PERIOD_BITS-1:0] count;

    always_ff @(posedge ss) begin
        if (rst) begin
            count <= '0;
            trigger <= 1'b0;
        end else if (!enable) begin
            // Hold the counter loaded so the first period is a full one
            count <= period;
            trigger <= 1'b0;
        end else if (count == '0) begin
            count <= period;
            trigger <= 1'b1;
        end else begin
            count <= count - 1'b1;
            trigger <= 1'b0;
        end
    end

endmodule

/* verilog/scope_regs.sv */
// APB slave without wait states; PERIOD resets to 1023 and SCLK_DIV to 3, drop count only clears on reset
module scope_regs (
    input  logic                                ss,
    input  logic                                rst,
    input  logic [scope_pkg::APB_ADDR_BITS-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [scope_pkg::APB_DATA_BITS-1:0] pwdata,
    output logic [scope_pkg::APB_DATA_BITS-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic                                busy,
    input  logic                                trigger,
    input  logic                                frame_dropped,
    output logic                                enable,
    output logic [scope_pkg::PERIOD_BITS-1:0]   period,
    output logic [scope_pkg::DIV_BITS-1:0]      sclk_div
);
    import scope_pkg::*;

    localparam logic [PERIOD_BITS-1:0] PERIOD_RESET = 16'd1023;
    localparam logic [DIV_BITS-1:0] DIV_RESET = 8'd3;
    localparam logic [7:0] DROP_MAX = 8'hFF;

    reg_addr_e  reg_addr;
    logic       addr_ok;
    logic       wr_en;
    logic       overrun;
    logic [7:0] drop_count;

    assign reg_addr = reg_addr_e'(paddr);
    assign wr_en = psel && penable && pwrite && addr_ok;
    assign pready = 1'b1;
    assign pslverr = psel && penable && !addr_ok;

    // Read mux, which also tells mapped offsets from unmapped ones
    always_comb begin
        prdata = '0;
        addr_ok = 1'b1;
        case (reg_addr)
            CTRL: prdata[0] = enable;
            PERIOD: prdata[PERIOD_BITS-1:0] = period;
            SCLK_DIV: prdata[DIV_BITS-1:0] = sclk_div;
            STATUS: begin
                prdata[0] = overrun;
                prdata[15:8] = drop_count;
            end
            default: addr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge ss) begin
        if (rst) begin
            enable <= 1'b0;
            period <= PERIOD_RESET;
            sclk_div <= DIV_RESET;
        end else if (wr_en) begin
            case (reg_addr)
                CTRL: enable <= pwdata[0];
                PERIOD: period <= pwdata[PERIOD_BITS-1:0];
                SCLK_DIV: sclk_div <= pwdata[DIV_BITS-1:0];
                default: ;
            endcase
        end
    end

    // A trigger that lands on a busy SPI master is lost
    // Setting wins over a clear in the same cycle
    always_ff @(posedge ss) begin
        if (rst) begin
            overrun <= 1'b0;
        end else if (trigger && busy) begin
            overrun <= 1'b1;
        end else if (wr_en && reg_addr == STATUS && pwdata[0]) begin
            overrun <= 1'b0;
        end
    end

    always_ff @(posedge ss) begin
        if (rst) begin
            drop_count <= '0;
        end else if (frame_dropped && drop_count != DROP_MAX) begin
            drop_count <= drop_count + 8'd1;
        end
    end

endmodule

/* verilog/scope_pkg.sv */
// Shared widths and encodings; register offsets assume a 4-bit APB byte address with 32-bit data
package scope_pkg;

    // ADC result width and SCLK cycles per conversion
    localparam int SAMPLE_BITS = 14;
    localparam int FRAME_BITS = 16;

    // APB bus widths
    localparam int APB_ADDR_BITS = 4;
    localparam int APB_DATA_BITS = 32;

    // Control field widths
    localparam int PERIOD_BITS = 16;
    localparam int DIV_BITS = 8;

    // Channel index on the output stream, enough for up to eight ADCs
    localparam int CHANNEL_BITS = 3;

    // Register map offsets
    typedef enum logic [APB_ADDR_BITS-1:0] {
        CTRL     = 4'h0,
        PERIOD   = 4'h4,
        SCLK_DIV = 4'h8,
        STATUS   = 4'hC
    } reg_addr_e;

    // SPI master sequence
    typedef enum logic [1:0] {
        IDLE,
        SELECT,
        SHIFT,
        RELEASE
    } spi_state_e;

    // Scope buffer sequence
    typedef enum logic [1:0] {
        FILL,
        DRAIN,
        WAIT_DMA
    } buf_state_e;

endpackage
